/* pipe_ctrl.f */
+incdir+verification
rtl/pipe_ctrl_pkg.sv
rtl/hazard_detect.sv
rtl/muldiv_busy.sv
rtl/pipeline_control.sv
rtl/pipe_stage_regs.sv
rtl/pipe_ctrl_top.sv
verification/tb_pipe_ctrl.sv

/* Makefile */
TOP := tb_pipe_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f pipe_ctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f pipe_ctrl.f --top-module $(TOP) \
	  -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_pipe_ctrl_vectors.svh */
// external hazard levels with an empty pipe and the ctrl_o they must give
typedef struct packed {
  logic                      ram_if;
  logic                      ram_mem;
  logic                      arb_ready;
  logic                      trap_flush;
  logic                      trap_stall;
  pipe_ctrl_pkg::pipe_ctrl_t exp;
} prio_row_t;

localparam int NUM_PRIO = 14;
localparam prio_row_t PRIO_ROWS [NUM_PRIO] = '{
  '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, pipe_ctrl_pkg::CTRL_NONE},
  '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, pipe_ctrl_pkg::CTRL_NONE},  // arbiter lets both go
  '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, pipe_ctrl_pkg::CTRL_NONE},
  '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, pipe_ctrl_pkg::CTRL_RAM_MEM},
  '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, pipe_ctrl_pkg::CTRL_RAM_MEM},
  '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, pipe_ctrl_pkg::CTRL_RAM_MEM},
  '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, pipe_ctrl_pkg::CTRL_RAM_MEM},
  '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, pipe_ctrl_pkg::CTRL_RAM_IF},
  '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, pipe_ctrl_pkg::CTRL_RAM_IF},
  '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, pipe_ctrl_pkg::CTRL_RAM_IF},
  '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, pipe_ctrl_pkg::CTRL_NONE},   // ready alone does nothing
  '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, pipe_ctrl_pkg::CTRL_TRAP_FLUSH},
  '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, pipe_ctrl_pkg::CTRL_TRAP_FLUSH},
  '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, pipe_ctrl_pkg::CTRL_TRAP_STALL}
};

// issued back to back per scenario
// retire edge = first accept edge + 4 + slot (+ MULDIV_CYCLES-1 if md_extra)
typedef struct packed {
  logic [1:0] scen;
  logic       is_load;
  logic       is_muldiv;
  logic       is_jump;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic       retires;
  logic       md_extra;
  logic [3:0] slot;
} flow_row_t;

localparam int NUM_FLOW = 17;
localparam flow_row_t FLOW_ROWS [NUM_FLOW] = '{
  '{2'd0, 1'b0, 1'b0, 1'b0, 5'd1, 5'd2, 5'd3, 1'b1, 1'b0, 4'd0},
  '{2'd0, 1'b1, 1'b0, 1'b0, 5'd7, 5'd1, 5'd0, 1'b1, 1'b0, 4'd1},
  '{2'd0, 1'b0, 1'b0, 1'b0, 5'd4, 5'd8, 5'd9, 1'b1, 1'b0, 4'd2},  // shares nothing with load
  '{2'd0, 1'b1, 1'b0, 1'b0, 5'd0, 5'd4, 5'd4, 1'b1, 1'b0, 4'd3},  // load into x0
  '{2'd0, 1'b0, 1'b0, 1'b0, 5'd5, 5'd0, 5'd0, 1'b1, 1'b0, 4'd4},
  '{2'd0, 1'b0, 1'b0, 1'b0, 5'd6, 5'd5, 5'd1, 1'b1, 1'b0, 4'd5},
  '{2'd1, 1'b1, 1'b0, 1'b0, 5'd5, 5'd1, 5'd2, 1'b1, 1'b0, 4'd0},
  '{2'd1, 1'b0, 1'b0, 1'b0, 5'd6, 5'd3, 5'd5, 1'b1, 1'b0, 4'd2},  // uses the load result
  '{2'd1, 1'b0, 1'b0, 1'b0, 5'd7, 5'd6, 5'd6, 1'b1, 1'b0, 4'd3},
  '{2'd2, 1'b0, 1'b1, 1'b0, 5'd8, 5'd1, 5'd2, 1'b1, 1'b1, 4'd0},
  '{2'd2, 1'b0, 1'b0, 1'b0, 5'd9, 5'd8, 5'd0, 1'b1, 1'b1, 4'd1},
  '{2'd2, 1'b0, 1'b0, 1'b0, 5'd10, 5'd3, 5'd4, 1'b1, 1'b1, 4'd2},
  '{2'd2, 1'b0, 1'b0, 1'b0, 5'd11, 5'd9, 5'd10, 1'b1, 1'b1, 4'd3},
  '{2'd3, 1'b0, 1'b0, 1'b1, 5'd1, 5'd2, 5'd0, 1'b1, 1'b0, 4'd0},
  '{2'd3, 1'b0, 1'b0, 1'b0, 5'd2, 5'd1, 5'd1, 1'b0, 1'b0, 4'd0},  // wrong path
  '{2'd3, 1'b1, 1'b0, 1'b0, 5'd3, 5'd2, 5'd0, 1'b0, 1'b0, 4'd0},  // wrong path
  '{2'd3, 1'b0, 1'b0, 1'b0, 5'd4, 5'd3, 5'd1, 1'b1, 1'b0, 4'd3}
};

// cycles each scenario spends in a given ctrl_o pattern
typedef struct packed {
  logic [3:0] load_use_hits;
  logic       muldiv_on;      // MULDIV_CYCLES-1 hits
  logic [3:0] jump_hits;
} scen_exp_t;

localparam int NUM_SCEN = 4;
localparam scen_exp_t SCEN_EXP [NUM_SCEN] = '{
  '{4'd0, 1'b0, 4'd0},
  '{4'd1, 1'b0, 4'd0},
  '{4'd0, 1'b1, 4'd0},
  '{4'd0, 1'b0, 4'd1}
};

task automatic check_ctrl(input string name, input pipe_ctrl_pkg::pipe_ctrl_t got,
                          input pipe_ctrl_pkg::pipe_ctrl_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s got 0x%03h expected 0x%03h", name, got, exp);
  end
endtask

task automatic check_retire(input string name, input pipe_ctrl_pkg::instr_desc_t got,
                            input pipe_ctrl_pkg::instr_desc_t exp);
  logic bad;
  checks++;
  bad = exp.valid ? (got !== exp) : (got.valid !== 1'b0);  // bubbles carry no payload
  if (bad) begin
    errors++;
    $display("error %s got 0x%08h expected 0x%08h", name, got, exp);
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  checks++;
  if (got != exp) begin
    errors++;
    $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

/* verification/tb_pipe_ctrl.sv */
`timescale 1ns/1ps

module tb_pipe_ctrl;

  localparam int MULDIV_CYCLES  = 4;
  localparam int ISSUE_TIMEOUT  = 20;
  localparam int RETIRE_TIMEOUT = 40;

  logic                       clk = 1'b0;
  logic                       rst;
  pipe_ctrl_pkg::instr_desc_t issue;
  logic                       ram_if;
  logic                       ram_mem;
  logic                       arb_ready;
  logic                       trap_flush;
  logic                       trap_stall;
  pipe_ctrl_pkg::pipe_ctrl_t  ctrl;
  pipe_ctrl_pkg::instr_desc_t retire;

  int cycle_cnt = 0;  // rising edges so far
  int checks    = 0;
  int errors    = 0;
  int timeouts  = 0;
  int lu_hits;
  int md_hits;
  int jump_hits;

  pipe_ctrl_pkg::instr_desc_t ret_desc [$];
  int                         ret_edge [$];
  bit                         tag_used [256];

  pipe_ctrl_top #(
    .MULDIV_CYCLES (MULDIV_CYCLES)
  ) dut0 (
    .clk               (clk),
    .rst               (rst),
    .issue_i           (issue),
    .ram_stall_if_i    (ram_if),
    .ram_stall_mem_i   (ram_mem),
    .arb_wdata_ready_i (arb_ready),
    .trap_flush_i      (trap_flush),
    .trap_stall_i      (trap_stall),
    .ctrl_o            (ctrl),
    .retire_o          (retire)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // sample mid low phase, registers and inputs both settled
  always begin
    @(negedge clk);
    #20;
    if (retire.valid === 1'b1) begin
      ret_desc.push_back(retire);
      ret_edge.push_back(cycle_cnt);
    end
    if (ctrl == pipe_ctrl_pkg::CTRL_LOAD_USE) lu_hits++;
    if (ctrl == pipe_ctrl_pkg::CTRL_MULDIV) md_hits++;
    if (ctrl == pipe_ctrl_pkg::CTRL_JUMP) jump_hits++;
  end

  `include "tb_pipe_ctrl_vectors.svh"

  function automatic logic [7:0] new_tag();
    logic [7:0] t;
    t = 8'($urandom());
    while (tag_used[t]) begin
      t = 8'($urandom());
    end
    tag_used[t] = 1'b1;  // unique within a scenario
    return t;
  endfunction

  function automatic pipe_ctrl_pkg::instr_desc_t make_desc(input flow_row_t r);
    pipe_ctrl_pkg::instr_desc_t d;
    d           = '0;
    d.valid     = 1'b1;
    d.tag       = new_tag();
    d.rd        = r.rd;
    d.rs1       = r.rs1;
    d.rs2       = r.rs2;
    d.is_load   = r.is_load;
    d.is_muldiv = r.is_muldiv;
    d.is_jump   = r.is_jump;
    d.pc_lo     = 4'($urandom());
    return d;
  endfunction

  // hold the entry until the PC stage is free to take it
  task automatic issue_desc(input pipe_ctrl_pkg::instr_desc_t d, output int acc_edge);
    int tries;
    tries    = 0;
    acc_edge = -1;
    @(negedge clk);
    issue = d;
    while (acc_edge < 0 && tries < ISSUE_TIMEOUT) begin
      #20;
      if (!ctrl.stall[pipe_ctrl_pkg::STG_PC] && !ctrl.flush[pipe_ctrl_pkg::STG_PC]) begin
        acc_edge = cycle_cnt + 1;  // taken at the coming rising edge
      end else begin
        @(negedge clk);
        tries++;
      end
    end
    if (acc_edge < 0) begin
      $display("timeout: entry with tag 0x%02h was never accepted", d.tag);
      timeouts++;
    end
  endtask

  task automatic run_scenario(input int s);
    pipe_ctrl_pkg::instr_desc_t exp_desc [$];
    int                         exp_edge [$];
    pipe_ctrl_pkg::instr_desc_t d;
    int                         acc_edge;
    int                         first_edge;
    int                         extra;
    int                         tries;
    first_edge = -1;
    tag_used   = '{default: 1'b0};
    ret_desc.delete();
    ret_edge.delete();
    lu_hits   = 0;
    md_hits   = 0;
    jump_hits = 0;
    for (int i = 0; i < NUM_FLOW; i++) begin
      if (FLOW_ROWS[i].scen == 2'(s) && timeouts == 0) begin
        d = make_desc(FLOW_ROWS[i]);
        issue_desc(d, acc_edge);
        if (first_edge < 0) first_edge = acc_edge;
        extra = FLOW_ROWS[i].md_extra ? MULDIV_CYCLES - 1 : 0;
        if (FLOW_ROWS[i].retires) begin
          exp_desc.push_back(d);
          exp_edge.push_back(first_edge + 4 + int'(FLOW_ROWS[i].slot) + extra);
        end
      end
    end
    @(negedge clk);
    issue = '0;

    tries = 0;
    while (ret_desc.size() < exp_desc.size() && tries < RETIRE_TIMEOUT) begin
      @(negedge clk);
      tries++;
    end
    if (ret_desc.size() < exp_desc.size()) begin
      $display("timeout: scenario %0d retired %0d of %0d entries", s, ret_desc.size(),
               exp_desc.size());
      timeouts++;
    end
    repeat (8) @(negedge clk);  // flushed entries would surface by now

    check_count("retire count", ret_desc.size(), exp_desc.size());
    for (int i = 0; i < exp_desc.size() && i < ret_desc.size(); i++) begin
      check_retire("retire_o", ret_desc[i], exp_desc[i]);
      check_count("retire edge", ret_edge[i], exp_edge[i]);
    end
    check_count("load_use cycles", lu_hits, int'(SCEN_EXP[s].load_use_hits));
    check_count("muldiv cycles", md_hits, SCEN_EXP[s].muldiv_on ? MULDIV_CYCLES - 1 : 0);
    check_count("jump cycles", jump_hits, int'(SCEN_EXP[s].jump_hits));
  endtask

  initial begin
    void'($urandom(32'hcb2aca71));
    rst        = 1'b1;
    issue      = '0;
    ram_if     = 1'b0;
    ram_mem    = 1'b0;
    arb_ready  = 1'b0;
    trap_flush = 1'b0;
    trap_stall = 1'b0;

    @(negedge clk);
    #20;
    check_ctrl("ctrl_o", ctrl, pipe_ctrl_pkg::CTRL_RESET);
    @(negedge clk);
    rst = 1'b0;  // two rising edges seen in reset
    @(negedge clk);
    #20;
    check_retire("retire_o", retire, '0);

    for (int i = 0; i < NUM_PRIO; i++) begin
      @(negedge clk);
      ram_if     = PRIO_ROWS[i].ram_if;
      ram_mem    = PRIO_ROWS[i].ram_mem;
      arb_ready  = PRIO_ROWS[i].arb_ready;
      trap_flush = PRIO_ROWS[i].trap_flush;
      trap_stall = PRIO_ROWS[i].trap_stall;
      #20;
      check_ctrl("ctrl_o", ctrl, PRIO_ROWS[i].exp);
    end
    @(negedge clk);
    ram_if     = 1'b0;
    ram_mem    = 1'b0;
    arb_ready  = 1'b0;
    trap_flush = 1'b0;
    trap_stall = 1'b0;

    // clean flow, load-use, muldiv, jump
    for (int s = 0; s < NUM_SCEN; s++) begin
      if (timeouts == 0) run_scenario(s);
    end

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* rtl/pipe_ctrl_top.sv */
`timescale 1ns/1ps

module pipe_ctrl_top #(
  parameter int MULDIV_CYCLES = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  pipe_ctrl_pkg::instr_desc_t issue_i,
  input  logic                       ram_stall_if_i,
  input  logic                       ram_stall_mem_i,
  input  logic                       arb_wdata_ready_i,
  input  logic                       trap_flush_i,
  input  logic                       trap_stall_i,
  output pipe_ctrl_pkg::pipe_ctrl_t  ctrl_o,
  output pipe_ctrl_pkg::instr_desc_t retire_o
);

  pipe_ctrl_pkg::instr_desc_t id_desc;
  pipe_ctrl_pkg::instr_desc_t ex_desc;
  pipe_ctrl_pkg::hazard_req_t req;
  logic                       load_use;
  logic                       muldiv;

  hazard_detect u_hazard (
    .id_i       (id_desc),
    .ex_i       (ex_desc),
    .load_use_o (load_use)
  );

  muldiv_busy #(
    .MULDIV_CYCLES (MULDIV_CYCLES)
  ) u_muldiv (
    .clk    (clk),
    .rst    (rst),
    .ex_i   (ex_desc),
    .busy_o (muldiv)
  );

  assign req = '{
    ram_if:          ram_stall_if_i,
    ram_mem:         ram_stall_mem_i,
    arb_wdata_ready: arb_wdata_ready_i,
    trap_flush:      trap_flush_i,
    trap_stall:      trap_stall_i,
    jump:            ex_desc.valid && ex_desc.is_jump,  // resolved in EX
    muldiv:          muldiv,
    load_use:        load_use
  };

  pipeline_control u_ctrl (
    .rst    (rst),
    .req_i  (req),
    .ctrl_o (ctrl_o)
  );

  pipe_stage_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .ctrl_i  (ctrl_o),
    .issue_i (issue_i),
    .id_o    (id_desc),
    .ex_o    (ex_desc),
    .mem_o   (),
    .wb_o    (retire_o)
  );

endmodule

/* rtl/pipe_stage_regs.sv */
`timescale 1ns/1ps

module pipe_stage_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  pipe_ctrl_pkg::pipe_ctrl_t  ctrl_i,
  input  pipe_ctrl_pkg::instr_desc_t issue_i,
  output pipe_ctrl_pkg::instr_desc_t id_o,
  output pipe_ctrl_pkg::instr_desc_t ex_o,
  output pipe_ctrl_pkg::instr_desc_t mem_o,
  output pipe_ctrl_pkg::instr_desc_t wb_o
);

  localparam int NUM_REGS = int'(pipe_ctrl_pkg::STG_MEM_WB) + 1;

  // [0] is the fetch holding register at the PC and [1..4] are IF_ID to MEM_WB
  pipe_ctrl_pkg::instr_desc_t stage_q [NUM_REGS];
  pipe_ctrl_pkg::instr_desc_t stage_d [NUM_REGS];

  always_comb begin
    pipe_ctrl_pkg::instr_desc_t upstream;
    logic                       up_held;
    for (int k = 0; k < NUM_REGS; k++) begin
      if (k == 0) begin
        upstream = issue_i;
        up_held  = 1'b0;
      end else begin
        upstream = stage_q[k-1];
        up_held  = ctrl_i.stall[k-1];
      end

      if (ctrl_i.flush[k]) begin
        stage_d[k] = '0;           // killed even when held
      end else if (ctrl_i.stall[k]) begin
        stage_d[k] = stage_q[k];
      end else if (up_held) begin
        // upstream keeps its entry so only a bubble moves down
        stage_d[k] = '0;
      end else begin
        stage_d[k] = upstream;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_REGS; k++) begin
      if (rst) begin
        stage_q[k].valid <= 1'b0;
      end else begin
        stage_q[k] <= stage_d[k];
      end
    end
  end

  assign id_o  = stage_q[pipe_ctrl_pkg::STG_IF_ID];
  assign ex_o  = stage_q[pipe_ctrl_pkg::STG_ID_EX];
  assign mem_o = stage_q[pipe_ctrl_pkg::STG_EX_MEM];
  assign wb_o  = stage_q[pipe_ctrl_pkg::STG_MEM_WB];

  // a flowing entry is never overwritten while the stage below holds
  for (genvar g = 0; g < NUM_REGS - 1; g++) begin : g_loss_chk
    a_no_loss: assert property (@(posedge clk) disable iff (rst)
      !(stage_q[g].valid && !ctrl_i.stall[g] && !ctrl_i.flush[g] &&
        ctrl_i.stall[g+1] && !ctrl_i.flush[g+1]));
  end

endmodule

/* rtl/pipeline_control.sv */
`timescale 1ns/1ps

module pipeline_control (
  input  logic                       rst,
  input  pipe_ctrl_pkg::hazard_req_t req_i,
  output pipe_ctrl_pkg::pipe_ctrl_t  ctrl_o
);

  // the further down the pipe the event, the higher its priority
  always_comb begin
    if (rst) begin
      ctrl_o = pipe_ctrl_pkg::CTRL_RESET;  // bubble every register
    end else if (req_i.ram_if && req_i.ram_mem && req_i.arb_wdata_ready) begin
      ctrl_o = pipe_ctrl_pkg::CTRL_NONE;   // arbiter takes the write, both ports move
    end else if (req_i.ram_mem) begin
      ctrl_o = pipe_ctrl_pkg::CTRL_RAM_MEM;  // freeze up to EX_MEM
    end else if (req_i.ram_if) begin
      ctrl_o = pipe_ctrl_pkg::CTRL_RAM_IF;
    end else if (req_i.trap_flush) begin
      ctrl_o = pipe_ctrl_pkg::CTRL_TRAP_FLUSH;
    end else if (req_i.trap_stall) begin
      ctrl_o = pipe_ctrl_pkg::CTRL_TRAP_STALL;
    end else if (req_i.jump) begin
      // younger entries in IF and ID are wrong path
      ctrl_o = pipe_ctrl_pkg::CTRL_JUMP;
    end else if (req_i.muldiv) begin
      ctrl_o = pipe_ctrl_pkg::CTRL_MULDIV;
    end else if (req_i.load_use) begin
      ctrl_o = pipe_ctrl_pkg::CTRL_LOAD_USE;
    end else begin
      ctrl_o = pipe_ctrl_pkg::CTRL_NONE;
    end
  end

  // a stage killed in place never hands its entry to a flowing stage below
  always_comb begin
    for (int k = 0; k < int'(pipe_ctrl_pkg::STG_RETIRE); k++) begin
      assert final (!(ctrl_o.stall[k] && ctrl_o.flush[k]) ||
                    ctrl_o.stall[k+1] || ctrl_o.flush[k+1]);
    end
  end

endmodule

/* rtl/muldiv_busy.sv */
`timescale 1ns/1ps

module muldiv_busy #(
  parameter int MULDIV_CYCLES = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  pipe_ctrl_pkg::instr_desc_t ex_i,
  output logic                       busy_o
);

  localparam int CNT_W = $clog2(MULDIV_CYCLES + 1);

  logic [CNT_W-1:0]           rem_q;        // EX cycles left incl. current (zero when idle)
  logic [CNT_W-1:0]           rem_now;
  logic                       done_q;       // finished op may still sit in EX
  pipe_ctrl_pkg::instr_desc_t done_desc_q;
  logic                       ex_md;
  logic                       start;

  assign ex_md = ex_i.valid && ex_i.is_muldiv;

  // an op held in EX after finishing must not be counted again
  assign start   = ex_md && (rem_q == '0) && !(done_q && (ex_i == done_desc_q));
  assign rem_now = start ? CNT_W'(MULDIV_CYCLES) : rem_q;

  // last cycle drops busy so the op can move on
  assign busy_o = ex_md && (rem_now > CNT_W'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      rem_q  <= '0;
      done_q <= 1'b0;
    end else if (!ex_md) begin
      rem_q  <= '0;  // op flushed or gone
      done_q <= 1'b0;
    end else if (rem_now > CNT_W'(1)) begin
      rem_q <= rem_now - CNT_W'(1);
    end else if (rem_now == CNT_W'(1)) begin
      rem_q  <= '0;
      done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_md && (rem_now == CNT_W'(1))) begin
      done_desc_q <= ex_i;  // remember which op completed
    end
  end

  // a counting op stays in EX until it finishes
  a_op_held: assert property (@(posedge clk) disable iff (rst)
    (rem_q != '0 && ex_md) |-> (ex_i == $past(ex_i)));

endmodule

/* rtl/hazard_detect.sv */
`timescale 1ns/1ps

module hazard_detect (
  input  pipe_ctrl_pkg::instr_desc_t id_i,
  input  pipe_ctrl_pkg::instr_desc_t ex_i,
  output logic                       load_use_o
);

  logic ex_load;
  logic rs1_hit;
  logic rs2_hit;

  // load in EX whose result is not ready for the entry behind it
  assign ex_load = ex_i.valid && ex_i.is_load && (ex_i.rd != 5'd0);  // x0 carries no value

  assign rs1_hit = (id_i.rs1 == ex_i.rd);
  assign rs2_hit = (id_i.rs2 == ex_i.rd);

  assign load_use_o = ex_load && id_i.valid && (rs1_hit || rs2_hit);

endmodule

/* rtl/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

  // bit positions inside the stall and flush vectors
  typedef enum logic [2:0] {
    STG_PC     = 3'd0,
    STG_IF_ID  = 3'd1,
    STG_ID_EX  = 3'd2,
    STG_EX_MEM = 3'd3,
    STG_MEM_WB = 3'd4,
    STG_RETIRE = 3'd5
  } stage_e;

  typedef logic [5:0] stage_vec_t;  // indexed by stage_e

  typedef struct packed {
    stage_vec_t stall;
    stage_vec_t flush;
  } pipe_ctrl_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] tag;       // sequence number from the source
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       is_load;
    logic       is_muldiv;
    logic       is_jump;
    logic [3:0] pc_lo;
  } instr_desc_t;

  typedef struct packed {
    logic ram_if;
    logic ram_mem;
    logic arb_wdata_ready;
    logic trap_flush;        // ecall style trap from wb
    logic trap_stall;        // csr style trap from wb
    logic jump;
    logic muldiv;
    logic load_use;
  } hazard_req_t;

  // stall/flush pairs per hazard
  localparam pipe_ctrl_t CTRL_NONE       = '{stall: 6'b000000, flush: 6'b000000};
  localparam pipe_ctrl_t CTRL_RESET      = '{stall: 6'b000000, flush: 6'b011111};
  localparam pipe_ctrl_t CTRL_RAM_MEM    = '{stall: 6'b001111, flush: 6'b010000};
  localparam pipe_ctrl_t CTRL_RAM_IF     = '{stall: 6'b000011, flush: 6'b000000};
  localparam pipe_ctrl_t CTRL_TRAP_FLUSH = '{stall: 6'b000010, flush: 6'b001110};
  localparam pipe_ctrl_t CTRL_TRAP_STALL = '{stall: 6'b111111, flush: 6'b001110};
  localparam pipe_ctrl_t CTRL_JUMP       = '{stall: 6'b000010, flush: 6'b000110};
  localparam pipe_ctrl_t CTRL_MULDIV     = '{stall: 6'b000111, flush: 6'b001000};
  localparam pipe_ctrl_t CTRL_LOAD_USE   = '{stall: 6'b000011, flush: 6'b000100};

endpackage
